// ==== design/cpu_bus_pkg.sv ====
`default_nettype none

package cpu_bus_pkg;

	// One data-bus request as the core presents it in a cycle.
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wmask;
		logic        wen;
	} data_req_t;

	// Word index of a register inside the timer region.
	typedef enum logic [1:0] {
		MTIME_LO    = 2'd0,
		MTIME_HI    = 2'd1,
		MTIMECMP_LO = 2'd2,
		MTIMECMP_HI = 2'd3
	} timer_reg_e;

	// Replaces the bytes of old_word whose mask bit is set.
	function automatic logic [31:0] merge_bytes(
		input logic [31:0] old_word,
		input logic [31:0] new_word,
		input logic [3:0]  mask
	);
		logic [31:0] merged;
		merged = old_word;
		for (int lane = 0; lane < 4; lane++)
		begin
			if (mask[lane])
				merged[8*lane +: 8] = new_word[8*lane +: 8];
		end
		return merged;
	endfunction

endpackage

`default_nettype wire

// ==== design/cpu_bus_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_bus_top
	import cpu_bus_pkg::*;
#(
	parameter int MEM_ADDR_W = 9
) (
	input  wire             clk_i,
	input  wire             reset_i,
	input  wire [31:0]      instr_addr_i,
	input  wire data_req_t  data_req_i,
	output logic [31:0]     instr_o,
	output logic [31:0]     data_o,
	output logic            mtip_o
);

	logic        sram_sel;
	logic        timer_sel;
	data_req_t   timer_req;
	logic [31:0] sram_rdata;
	logic [31:0] timer_rdata;

	data_bus_fabric #(
		.MEM_ADDR_W (MEM_ADDR_W)
	) fabric (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.data_req_i    (data_req_i),
		.sram_rdata_i  (sram_rdata),
		.timer_rdata_i (timer_rdata),
		.sram_sel_o    (sram_sel),
		.timer_req_o   (timer_req),
		.timer_sel_o   (timer_sel),
		.data_o        (data_o)
	);

	// The data port gets the request as the core drives it.
	dual_port_sram #(
		.MEM_ADDR_W (MEM_ADDR_W)
	) sram (
		.clk_i        (clk_i),
		.sel_i        (sram_sel),
		.req_i        (data_req_i),
		.instr_addr_i (instr_addr_i),
		.rdata_o      (sram_rdata),
		.instr_o      (instr_o)
	);

	// The timer gets the registered request from the fabric.
	machine_timer timer (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.sel_i   (timer_sel),
		.req_i   (timer_req),
		.rdata_o (timer_rdata),
		.mtip_o  (mtip_o)
	);

endmodule

`default_nettype wire

// ==== design/data_bus_fabric.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_bus_fabric
	import cpu_bus_pkg::*;
#(
	parameter int MEM_ADDR_W = 9
) (
	input  wire             clk_i,
	input  wire             reset_i,
	input  wire data_req_t  data_req_i,
	input  wire [31:0]      sram_rdata_i,
	input  wire [31:0]      timer_rdata_i,
	output logic            sram_sel_o,
	output data_req_t       timer_req_o,
	output logic            timer_sel_o,
	output logic [31:0]     data_o
);

	// The bit just above the SRAM word range picks the region.
	localparam int REGION_BIT = MEM_ADDR_W + 2;

	logic      region_timer;
	logic      timer_sel;
	logic      timer_sel_q;
	data_req_t timer_req_q;

	assign region_timer = data_req_i.addr[REGION_BIT];

	// Neither target is selected while reset is held.
	assign sram_sel_o = !region_timer && reset_i;
	assign timer_sel  = region_timer && reset_i;

	// The timer sees the request one cycle after the SRAM does.
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			timer_req_q <= '0;
		else
			timer_req_q <= data_req_i;
	end

	// The same registered select marks which read data is valid now.
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			timer_sel_q <= 1'b0;
		else
			timer_sel_q <= timer_sel;
	end

	assign timer_req_o = timer_req_q;
	assign timer_sel_o = timer_sel_q;

	// SRAM data is registered inside the SRAM and timer data is decoded from the
	// registered request, so both are valid one cycle after the request.
	assign data_o = timer_sel_q ? timer_rdata_i : sram_rdata_i;

	a_one_region: assert property (
		@(posedge clk_i) disable iff (!reset_i)
		!(sram_sel_o && timer_sel)
	) else $error("request decoded into both regions");

endmodule

`default_nettype wire

// ==== design/dual_port_sram.sv ====
`timescale 1ns/1ns
`default_nettype none

module dual_port_sram
	import cpu_bus_pkg::*;
#(
	parameter int MEM_ADDR_W = 9
) (
	input  wire             clk_i,
	input  wire             sel_i,
	input  wire data_req_t  req_i,
	input  wire [31:0]      instr_addr_i,
	output logic [31:0]     rdata_o,
	output logic [31:0]     instr_o
);

	localparam int DEPTH = 1 << MEM_ADDR_W;

	logic [31:0] mem [DEPTH];

	logic [MEM_ADDR_W-1:0] data_idx;
	logic [MEM_ADDR_W-1:0] instr_idx;

	// Both ports address whole words, so the byte offset is dropped.
	assign data_idx  = req_i.addr[MEM_ADDR_W+1:2];
	assign instr_idx = instr_addr_i[MEM_ADDR_W+1:2];

	// Port 0 serves the data bus.
	// A read in the same cycle as a write to the same word returns the old contents.
	always_ff @(posedge clk_i)
	begin
		if (sel_i)
		begin
			if (req_i.wen)
			begin
				for (int lane = 0; lane < 4; lane++)
				begin
					if (req_i.wmask[lane])
						mem[data_idx][8*lane +: 8] <= req_i.wdata[8*lane +: 8];
				end
			end
			rdata_o <= mem[data_idx];
		end
	end

	// Port 1 is the fetch port and reads every cycle.
	always_ff @(posedge clk_i)
	begin
		instr_o <= mem[instr_idx];
	end

	// The select comes from the fabric's region decode.
	// A write it lets through must carry a known word address.
	a_write_addr_known: assert property (
		@(posedge clk_i)
		(sel_i && req_i.wen) |-> !$isunknown(data_idx)
	) else $error("SRAM write with unknown address");

	// A write must also say which lanes it touches.
	a_write_data_known: assert property (
		@(posedge clk_i)
		(sel_i && req_i.wen) |-> !$isunknown(req_i.wmask)
	) else $error("SRAM write with unknown byte mask");

endmodule

`default_nettype wire

// ==== design/machine_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module machine_timer
	import cpu_bus_pkg::*;
(
	input  wire             clk_i,
	input  wire             reset_i,
	input  wire             sel_i,
	input  wire data_req_t  req_i,
	output logic [31:0]     rdata_o,
	output logic            mtip_o
);

	logic [63:0] mtime_q;
	logic [63:0] mtimecmp_q;
	logic [63:0] mtime_inc;

	timer_reg_e reg_idx;
	logic       wr_en;
	logic       wr_mtime_lo;
	logic       wr_mtime_hi;
	logic       wr_cmp_lo;
	logic       wr_cmp_hi;

	// The request arrives one cycle late from the fabric's register.
	assign reg_idx = timer_reg_e'(req_i.addr[3:2]);
	assign wr_en   = sel_i && req_i.wen;

	assign wr_mtime_lo = wr_en && (reg_idx == MTIME_LO);
	assign wr_mtime_hi = wr_en && (reg_idx == MTIME_HI);
	assign wr_cmp_lo   = wr_en && (reg_idx == MTIMECMP_LO);
	assign wr_cmp_hi   = wr_en && (reg_idx == MTIMECMP_HI);

	assign mtime_inc = mtime_q + 64'd1;

	// mtime counts every clock.
	// A written half takes the merged bytes and skips the increment.
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			mtime_q <= '0;
		end
		else
		begin
			mtime_q <= mtime_inc;
			if (wr_mtime_lo)
				mtime_q[31:0] <= merge_bytes(mtime_q[31:0], req_i.wdata, req_i.wmask);
			if (wr_mtime_hi)
				mtime_q[63:32] <= merge_bytes(mtime_q[63:32], req_i.wdata, req_i.wmask);
		end
	end

	// The compare value resets to all ones so that no interrupt is pending.
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			mtimecmp_q <= '1;
		end
		else
		begin
			if (wr_cmp_lo)
				mtimecmp_q[31:0] <= merge_bytes(mtimecmp_q[31:0], req_i.wdata, req_i.wmask);
			if (wr_cmp_hi)
				mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], req_i.wdata, req_i.wmask);
		end
	end

	// Read data follows the registered address without another register stage.
	always_comb
	begin
		unique case (reg_idx)
			MTIME_LO:    rdata_o = mtime_q[31:0];
			MTIME_HI:    rdata_o = mtime_q[63:32];
			MTIMECMP_LO: rdata_o = mtimecmp_q[31:0];
			MTIMECMP_HI: rdata_o = mtimecmp_q[63:32];
			default:     rdata_o = '0;
		endcase
	end

	assign mtip_o = (mtime_q >= mtimecmp_q);

	// The index is taken from the registered request, one cycle after the core drove it.
	a_write_index_known: assert property (
		@(posedge clk_i) disable iff (!reset_i)
		wr_en |-> !$isunknown(req_i.addr[3:2])
	) else $error("timer write with unknown register index");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_cpu_bus -f sim.f --Mdir obj_dir -o tb_cpu_bus

./obj_dir/tb_cpu_bus | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
	echo "Simulation reported a failure."
	exit 1
fi

echo "Simulation finished without failures."

// ==== sim.f ====
design/cpu_bus_pkg.sv
design/data_bus_fabric.sv
design/dual_port_sram.sv
design/machine_timer.sv
design/cpu_bus_top.sv
testbench/cpu_bus_model.sv
testbench/tb_cpu_bus.sv

// ==== testbench/cpu_bus_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_bus_model
	import cpu_bus_pkg::*;
#(
	parameter int MEM_ADDR_W = 9
) (
	input wire clk_i,
	input wire reset_i
);

	localparam int DEPTH = 1 << MEM_ADDR_W;

	logic [31:0] sram_words [DEPTH];

	// Rising edges since reset release.
	logic [63:0] cycles;

	// mtime counts on from the value and the edge of its last write.
	logic [63:0] mtime_base;
	logic [63:0] mtime_edge;

	// mtimecmp before and after its last write, and the edge where that write landed.
	logic [63:0] cmp_before;
	logic [63:0] cmp_after;
	logic [63:0] cmp_edge;

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			cycles <= '0;
		else
			cycles <= cycles + 64'd1;
	end

	function automatic logic [31:0] lane_merge(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] mask);
		logic [31:0] lane_bits;
		lane_bits = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
		return (old_word & ~lane_bits) | (new_word & lane_bits);
	endfunction

	task automatic clear();
		mtime_base = '0;
		mtime_edge = '0;
		cmp_before = '1;
		cmp_after  = '1;
		cmp_edge   = '0;
	endtask

	task automatic sram_write(input logic [MEM_ADDR_W-1:0] idx, input logic [31:0] data,
		input logic [3:0] mask);
		sram_words[idx] = lane_merge(sram_words[idx], data, mask);
	endtask

	function automatic logic [31:0] sram_read(input logic [MEM_ADDR_W-1:0] idx);
		return sram_words[idx];
	endfunction

	function automatic logic [63:0] mtime_at(input logic [63:0] c);
		return mtime_base + (c - mtime_edge);
	endfunction

	function automatic logic [63:0] mtimecmp_at(input logic [63:0] c);
		return (c >= cmp_edge) ? cmp_after : cmp_before;
	endfunction

	function automatic logic mtip_at(input logic [63:0] c);
		return mtime_at(c) >= mtimecmp_at(c);
	endfunction

	function automatic logic [31:0] timer_read(input logic [1:0] reg_idx, input logic [63:0] c);
		logic [63:0] mtime_now;
		logic [63:0] cmp_now;
		mtime_now = mtime_at(c);
		cmp_now   = mtimecmp_at(c);
		case (timer_reg_e'(reg_idx))
			MTIME_LO:    return mtime_now[31:0];
			MTIME_HI:    return mtime_now[63:32];
			MTIMECMP_LO: return cmp_now[31:0];
			default:     return cmp_now[63:32];
		endcase
	endfunction

	// The write lands on edge edge_c and merges into the value left by the edge before.
	task automatic timer_write(input logic [1:0] reg_idx, input logic [31:0] data,
		input logic [3:0] mask, input logic [63:0] edge_c);
		logic [63:0] old_val;
		logic [63:0] new_val;
		if (reg_idx == MTIME_LO || reg_idx == MTIME_HI)
		begin
			old_val = mtime_at(edge_c - 64'd1);
			// The other half keeps counting, carry included.
			new_val = old_val + 64'd1;
		end
		else
		begin
			old_val = mtimecmp_at(edge_c - 64'd1);
			new_val = old_val;
		end
		if (reg_idx[0])
			new_val[63:32] = lane_merge(old_val[63:32], data, mask);
		else
			new_val[31:0] = lane_merge(old_val[31:0], data, mask);
		if (reg_idx == MTIME_LO || reg_idx == MTIME_HI)
		begin
			mtime_base = new_val;
			mtime_edge = edge_c;
		end
		else
		begin
			cmp_before = old_val;
			cmp_after  = new_val;
			cmp_edge   = edge_c;
		end
	endtask

endmodule

`default_nettype wire

// ==== testbench/tb_cpu_bus.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_bus
	import cpu_bus_pkg::*;
();

	localparam int MEM_ADDR_W = 9;
	localparam int DEPTH      = 1 << MEM_ADDR_W;
	localparam int REGION_BIT = MEM_ADDR_W + 2;

	logic        clk;
	logic        reset_n;
	logic [31:0] instr_addr;
	data_req_t   data_req;
	logic [31:0] instr_word;
	logic [31:0] data_word;
	logic        mtip;

	string test_name;
	int    test_errors;
	int    total_errors;
	int    tests_run;
	int    tests_failed;

	cpu_bus_top #(
		.MEM_ADDR_W (MEM_ADDR_W)
	) uut (
		.clk_i        (clk),
		.reset_i      (reset_n),
		.instr_addr_i (instr_addr),
		.data_req_i   (data_req),
		.instr_o      (instr_word),
		.data_o       (data_word),
		.mtip_o       (mtip)
	);

	cpu_bus_model #(
		.MEM_ADDR_W (MEM_ADDR_W)
	) model (
		.clk_i   (clk),
		.reset_i (reset_n)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errors == 0)
			$display("test %s passed", test_name);
		else
		begin
			tests_failed++;
			$display("test %s failed with %0d errors", test_name, test_errors);
		end
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
		test_errors++;
		total_errors++;
	endtask

	task automatic report_failure(input string what);
		$display("[ERROR] %s: %s", test_name, what);
		test_errors++;
		total_errors++;
	endtask

	function automatic data_req_t make_req(input logic [31:0] addr, input logic [31:0] wdata,
		input logic [3:0] wmask, input logic wen);
		data_req_t req;
		req.addr  = addr;
		req.wdata = wdata;
		req.wmask = wmask;
		req.wen   = wen;
		return req;
	endfunction

	function automatic logic [31:0] sram_addr(input logic [MEM_ADDR_W-1:0] idx);
		return 32'(idx) << 2;
	endfunction

	// The timer registers repeat every four words, so the bits above the index are random.
	function automatic logic [MEM_ADDR_W-1:0] timer_word(input timer_reg_e r);
		return MEM_ADDR_W'({$urandom, r});
	endfunction

	function automatic logic [31:0] timer_addr(input logic [MEM_ADDR_W-1:0] word);
		return (32'd1 << REGION_BIT) | (32'(word) << 2);
	endfunction

	function automatic logic [31:0] fill_word(input int unsigned a);
		return (a * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
	endfunction

	// Drives one request on the falling edge and returns on the next falling edge.
	task automatic drive_cycle(input data_req_t req);
		data_req = req;
		@(negedge clk);
	endtask

	task automatic idle_cycle();
		drive_cycle(make_req(32'd0, 32'd0, 4'd0, 1'b0));
	endtask

	task automatic write_sram(input logic [MEM_ADDR_W-1:0] idx, input logic [31:0] data,
		input logic [3:0] mask);
		model.sram_write(idx, data, mask);
		drive_cycle(make_req(sram_addr(idx), data, mask, 1'b1));
	endtask

	task automatic check_sram_read(input logic [MEM_ADDR_W-1:0] idx);
		logic [31:0] expected;
		expected = model.sram_read(idx);
		drive_cycle(make_req(sram_addr(idx), $urandom, 4'($urandom), 1'b0));
		if (data_word !== expected)
			report_mismatch($sformatf("sram word %0d", idx), expected, data_word);
	endtask

	// The fabric register moves a timer write to the second rising edge.
	task automatic write_timer(input logic [MEM_ADDR_W-1:0] word, input logic [31:0] data,
		input logic [3:0] mask);
		model.timer_write(word[1:0], data, mask, model.cycles + 64'd2);
		drive_cycle(make_req(timer_addr(word), data, mask, 1'b1));
	endtask

	task automatic check_timer_read(input logic [MEM_ADDR_W-1:0] word);
		logic [31:0] expected;
		drive_cycle(make_req(timer_addr(word), $urandom, 4'($urandom), 1'b0));
		expected = model.timer_read(word[1:0], model.cycles);
		if (data_word !== expected)
			report_mismatch($sformatf("timer register %0d", word[1:0]), expected, data_word);
	endtask

	task automatic check_mtip();
		if (mtip !== model.mtip_at(model.cycles))
			report_mismatch("mtip", 32'(model.mtip_at(model.cycles)), 32'(mtip));
	endtask

	task automatic reset_state();
		start_test("reset_state");
		if (mtip !== 1'b0)
			report_mismatch("mtip after reset", 32'd0, 32'(mtip));
		check_timer_read(timer_word(MTIME_LO));
		drive_cycle(make_req(timer_addr(timer_word(MTIMECMP_LO)), 32'd0, 4'd0, 1'b0));
		if (data_word !== 32'hffff_ffff)
			report_mismatch("mtimecmp low", 32'hffff_ffff, data_word);
		drive_cycle(make_req(timer_addr(timer_word(MTIMECMP_HI)), 32'd0, 4'd0, 1'b0));
		if (data_word !== 32'hffff_ffff)
			report_mismatch("mtimecmp high", 32'hffff_ffff, data_word);
		finish_test();
	endtask

	task automatic sram_access();
		logic [MEM_ADDR_W-1:0] idx;
		start_test("sram_access");
		for (int i = 0; i < DEPTH; i++)
			write_sram(MEM_ADDR_W'(i), fill_word(i), 4'hf);
		for (int i = 0; i < DEPTH; i += 37)
			check_sram_read(MEM_ADDR_W'(i));
		repeat (200)
		begin
			idx = MEM_ADDR_W'($urandom);
			write_sram(idx, $urandom, 4'($urandom));
			check_sram_read(idx);
			check_sram_read(MEM_ADDR_W'($urandom));
		end
		finish_test();
	endtask

	task automatic instr_fetch();
		logic [MEM_ADDR_W-1:0] idx;
		start_test("instr_fetch");
		repeat (100)
		begin
			idx = MEM_ADDR_W'($urandom);
			write_sram(idx, $urandom, 4'($urandom));
			// This fetch comes right after the write and must see the merged word.
			instr_addr = sram_addr(idx);
			idle_cycle();
			if (instr_word !== model.sram_read(idx))
				report_mismatch("fetch after write", model.sram_read(idx), instr_word);
			idx = MEM_ADDR_W'($urandom);
			instr_addr = sram_addr(idx);
			idle_cycle();
			if (instr_word !== model.sram_read(idx))
				report_mismatch("random fetch", model.sram_read(idx), instr_word);
		end
		finish_test();
	endtask

	task automatic mtime_counting();
		logic [31:0] first;
		logic [31:0] second;
		int          gap;
		start_test("mtime_counting");
		check_timer_read(timer_word(MTIME_LO));
		first = data_word;
		gap = 2 + int'($urandom % 30);
		repeat (gap)
			idle_cycle();
		check_timer_read(timer_word(MTIME_LO));
		second = data_word;
		// The two samples are gap + 1 clocks apart.
		if (second - first !== 32'(gap + 1))
			report_mismatch("mtime step", 32'(gap + 1), second - first);
		repeat (8)
		begin
			write_timer(timer_word(MTIME_LO), $urandom, 4'($urandom));
			check_timer_read(timer_word(MTIME_LO));
			check_timer_read(timer_word(MTIME_HI));
		end
		write_timer(timer_word(MTIME_HI), $urandom, 4'($urandom));
		check_timer_read(timer_word(MTIME_HI));
		// A small upper half keeps later compare values far from wrapping.
		write_timer(timer_word(MTIME_HI), 32'd0, 4'hf);
		check_timer_read(timer_word(MTIME_HI));
		check_timer_read(timer_word(MTIME_LO));
		check_mtip();
		finish_test();
	endtask

	task automatic interrupt_level();
		logic [63:0] target;
		int          waited;
		start_test("interrupt_level");
		target = model.mtime_at(model.cycles) + 64'(20 + $urandom % 80);
		write_timer(timer_word(MTIMECMP_HI), target[63:32], 4'hf);
		write_timer(timer_word(MTIMECMP_LO), target[31:0], 4'hf);
		check_mtip();
		waited = 0;
		while (mtip !== 1'b1 && waited < 200)
		begin
			idle_cycle();
			check_mtip();
			waited++;
		end
		if (mtip !== 1'b1)
			report_failure("mtip_o did not rise before the timeout");
		repeat (5)
		begin
			idle_cycle();
			if (mtip !== 1'b1)
				report_mismatch("mtip held", 32'd1, 32'(mtip));
		end
		write_timer(timer_word(MTIMECMP_HI), 32'hffff_ffff, 4'hf);
		write_timer(timer_word(MTIMECMP_LO), 32'hffff_ffff, 4'hf);
		idle_cycle();
		if (mtip !== 1'b0)
			report_mismatch("mtip cleared", 32'd0, 32'(mtip));
		check_timer_read(timer_word(MTIMECMP_LO));
		check_timer_read(timer_word(MTIMECMP_HI));
		finish_test();
	endtask

	task automatic region_isolation();
		logic [MEM_ADDR_W-1:0] idx;
		start_test("region_isolation");
		repeat (20)
		begin
			// Bit 1 set makes the aliased timer word one of the compare halves.
			idx = MEM_ADDR_W'($urandom) | MEM_ADDR_W'(2);
			write_timer(idx, $urandom, 4'($urandom));
			check_sram_read(idx);
			check_sram_read(idx);
			write_sram(MEM_ADDR_W'($urandom), $urandom, 4'($urandom));
			check_timer_read(timer_word(MTIMECMP_LO));
			check_timer_read(timer_word(MTIMECMP_HI));
			check_timer_read(timer_word(MTIME_LO));
			check_mtip();
		end
		finish_test();
	endtask

	initial
	begin
		void'($urandom(32'hfcf056ee));
		reset_n      = 1'b0;
		instr_addr   = 32'd0;
		data_req     = '0;
		total_errors = 0;
		tests_run    = 0;
		tests_failed = 0;
		model.clear();
		repeat (3)
			@(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
		reset_state();
		sram_access();
		instr_fetch();
		mtime_counting();
		interrupt_level();
		region_isolation();
		$display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
			total_errors);
		if (total_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
